// File: logic/ring_pkg.sv
// =========================================================
// Host ring channel shared definitions: memory request kinds,
// Wishbone widths and register byte offsets
// =========================================================
`default_nettype none

package ring_pkg;

    // Kind of request placed on the memory write port
    typedef enum logic
    {
        REQ_LINE  = 1'b0,
        REQ_FENCE = 1'b1
    } req_type_t;

    // Register byte offset width on the Wishbone slave port
    localparam int WB_ADDR_WIDTH = 4;

    // Data width of the Wishbone slave port
    localparam int WB_DATA_WIDTH = 32;

    // Register map, byte offsets
    localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL      = 4'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_BASE      = 4'd4;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_OLDEST    = 4'd8;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_PUBLISHED = 4'd12;

endpackage

`default_nettype wire

// File: logic/line_fifo.sv
// =========================================================
// Two-entry line buffer between the producer and the writer
// =========================================================
`timescale 1ns/1ns
`default_nettype none

module line_fifo
#(
    parameter int DATA_WIDTH = 64
)
(
    input  logic                  clk,
    input  logic                  resetb,

    input  logic [DATA_WIDTH-1:0] enq_data,
    input  logic                  enq_en,
    output logic                  not_full,

    output logic [DATA_WIDTH-1:0] first,
    input  logic                  deq_en,
    output logic                  not_empty
);

    // Entry 0 is always the head, entry 1 the line behind it
    logic [DATA_WIDTH-1:0] entry0;
    logic [DATA_WIDTH-1:0] entry1;
    logic [1:0]            count;

    logic do_enq;
    logic do_deq;

    assign not_full  = (count != 2'd2);
    assign not_empty = (count != 2'd0);
    assign first     = entry0;

    // Only act on requests the buffer can honor
    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    // Occupancy count
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            count <= 2'd0;
        end
        else if (do_enq && !do_deq)
        begin
            count <= count + 2'd1;
        end
        else if (do_deq && !do_enq)
        begin
            count <= count - 2'd1;
        end
    end

    // Payload shifts toward the head on a dequeue
    always_ff @(posedge clk)
    begin
        if (do_deq)
        begin
            // The second entry moves up, or a new line lands straight at the head
            if (count == 2'd2)
                entry0 <= entry1;
            else if (do_enq)
                entry0 <= enq_data;
        end
        else if (do_enq)
        begin
            if (count == 2'd0)
                entry0 <= enq_data;
            else
                entry1 <= enq_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/ring_csr.sv
// =========================================================
// Wishbone classic register block that steers the ring writer:
// enable, ring base, host oldest index and published index
// =========================================================
`timescale 1ns/1ns
`default_nettype none

module ring_csr
    import ring_pkg::*;
#(
    parameter int IDX_WIDTH  = 6,
    parameter int ADDR_WIDTH = 32
)
(
    input  logic                     clk,
    input  logic                     resetb,

    // Wishbone classic slave
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [WB_DATA_WIDTH-1:0] wb_dat_w,
    output logic [WB_DATA_WIDTH-1:0] wb_dat_r,
    output logic                     wb_ack,

    // Writer control
    output logic                     ring_en,
    output logic [ADDR_WIDTH-1:0]    ring_base,
    output logic [IDX_WIDTH-1:0]     oldest_idx,
    input  logic [IDX_WIDTH-1:0]     published_idx
);

    // =========================================================
    // Bus handshake
    // =========================================================

    // Set once a transfer has been acknowledged and held until strobe drops
    logic ack_done;

    // A new transfer is seen when the master strobes and nothing is pending
    logic wb_req;
    assign wb_req = wb_cyc && wb_stb && !wb_ack && !ack_done;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            wb_ack   <= 1'b0;
            ack_done <= 1'b0;
        end
        else
        begin
            // Single-cycle acknowledge on the edge after the request
            wb_ack <= wb_req;

            if (!wb_stb)
                ack_done <= 1'b0;
            else if (wb_ack)
                ack_done <= 1'b1;
        end
    end

    // =========================================================
    // Registers
    // =========================================================

    // Writes take effect on the same edge that raises the acknowledge
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            ring_en    <= 1'b0;
            ring_base  <= '0;
            oldest_idx <= '0;
        end
        else if (wb_req && wb_we)
        begin
            case (wb_adr)
                REG_CTRL:   ring_en    <= wb_dat_w[0];
                REG_BASE:   ring_base  <= wb_dat_w[ADDR_WIDTH-1:0];
                REG_OLDEST: oldest_idx <= wb_dat_w[IDX_WIDTH-1:0];
                default:    ;
            endcase
        end
    end

    // Read data follows the address so the ack cycle shows the current value
    always_comb
    begin
        case (wb_adr)
            REG_CTRL:      wb_dat_r = WB_DATA_WIDTH'(ring_en);
            REG_BASE:      wb_dat_r = WB_DATA_WIDTH'(ring_base);
            REG_OLDEST:    wb_dat_r = WB_DATA_WIDTH'(oldest_idx);
            REG_PUBLISHED: wb_dat_r = WB_DATA_WIDTH'(published_idx);
            default:       wb_dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/ring_writer.sv
// =========================================================
// Ring buffer writer: stores lines into the host ring, issues
// fences and publishes the committed index to the host
// =========================================================
`timescale 1ns/1ns
`default_nettype none

module ring_writer
    import ring_pkg::*;
#(
    parameter int DATA_WIDTH = 64,
    parameter int IDX_WIDTH  = 6,
    parameter int ADDR_WIDTH = 32,
    parameter int IDLE_BITS  = 4
)
(
    input  logic                  clk,
    input  logic                  resetb,

    // Head of the input line buffer
    input  logic [DATA_WIDTH-1:0] head_data,
    input  logic                  head_valid,
    output logic                  head_deq,

    // Control from the register block
    input  logic                  ring_en,
    input  logic [ADDR_WIDTH-1:0] ring_base,
    input  logic [IDX_WIDTH-1:0]  oldest_idx,
    output logic [IDX_WIDTH-1:0]  published_idx,

    // Memory write port
    output logic                  mem_req,
    output req_type_t             mem_type,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0] mem_data,
    input  logic                  mem_gnt,
    input  logic                  mem_ready
);

    typedef enum logic [1:0]
    {
        ST_WAIT_EMPTY,
        ST_WAIT_DATA,
        ST_EMIT_FENCE
    } state_t;

    state_t state;

    // =========================================================
    // Ring indices
    // =========================================================

    // Next entry to write
    logic [IDX_WIDTH-1:0] cur_idx;
    logic [IDX_WIDTH-1:0] next_idx;
    assign next_idx = cur_idx + IDX_WIDTH'(1);

    // One slot stays free so that a full ring differs from an empty one
    logic room;
    assign room = (next_idx != oldest_idx);

    // Fence once a quarter of the ring has been written since the last publish
    logic flush_for_writes;
    assign flush_for_writes = (cur_idx[IDX_WIDTH-2] != published_idx[IDX_WIDTH-2]);

    // =========================================================
    // Request generation
    // =========================================================

    // Remembers a request left waiting for a grant so it is held until granted
    logic req_wait;

    logic new_req;
    logic line_gnt;
    logic fence_gnt;
    logic req_stall;

    // Fences ignore room since they never add entries
    assign new_req = ring_en &&
                     ((state == ST_EMIT_FENCE) || (head_valid && room));

    assign mem_req   = req_wait || new_req;
    assign req_stall = mem_req && !mem_gnt;

    assign line_gnt  = mem_req && mem_gnt && (state != ST_EMIT_FENCE);
    assign fence_gnt = mem_req && mem_gnt && (state == ST_EMIT_FENCE);

    // The head line leaves the buffer on its grant edge
    assign head_deq = line_gnt;

    // A fence carries no payload, so its data stays fixed while the buffer fills
    assign mem_data = (state == ST_EMIT_FENCE) ? '0 : head_data;
    assign mem_type = (state == ST_EMIT_FENCE) ? REQ_FENCE : REQ_LINE;
    assign mem_addr = (state == ST_EMIT_FENCE) ? '0 :
                      ring_base + ADDR_WIDTH'(cur_idx);

    always_ff @(posedge clk)
    begin
        if (!resetb)
            req_wait <= 1'b0;
        else
            req_wait <= req_stall;
    end

    // =========================================================
    // Idle flush
    // =========================================================

    logic [IDLE_BITS-1:0] idle_cnt;
    logic                 flush_idle_hold;
    logic                 flush_for_idle;

    // The top counter bit requests a flush and the hold keeps it until the fence
    assign flush_for_idle = idle_cnt[IDLE_BITS-1] || flush_idle_hold;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            flush_idle_hold <= 1'b0;
        end
        else
        begin
            flush_idle_hold <= flush_for_idle && (state != ST_EMIT_FENCE);
        end
    end

    // Idle cycles only count when unfenced lines exist and the port could
    // take a request, so a saturated memory port never forces extra fences
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            idle_cnt <= '0;
        end
        else if ((state != ST_WAIT_DATA) || head_valid)
        begin
            idle_cnt <= '0;
        end
        else if (mem_ready)
        begin
            idle_cnt <= idle_cnt + IDLE_BITS'(1);
        end
    end

    // =========================================================
    // State machine
    // =========================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state         <= ST_WAIT_EMPTY;
            cur_idx       <= '0;
            published_idx <= '0;
        end
        else
        begin
            case (state)
                ST_WAIT_EMPTY:
                begin
                    // First line since the last publish
                    if (line_gnt)
                    begin
                        state   <= ST_WAIT_DATA;
                        cur_idx <= next_idx;
                    end
                end

                ST_WAIT_DATA:
                begin
                    if (line_gnt)
                        cur_idx <= next_idx;

                    // A waiting line request must finish before switching to the fence
                    if ((flush_for_idle || flush_for_writes) && !req_stall)
                        state <= ST_EMIT_FENCE;
                end

                ST_EMIT_FENCE:
                begin
                    // Everything written so far is now safe for the host to read
                    if (fence_gnt)
                    begin
                        state         <= ST_WAIT_EMPTY;
                        published_idx <= cur_idx;
                    end
                end

                default:
                begin
                    state <= ST_WAIT_EMPTY;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/host_ring_top.sv
// =========================================================
// FPGA-to-host message channel: input buffer, register block
// and ring writer on one memory write port
// =========================================================
`timescale 1ns/1ns
`default_nettype none

module host_ring_top
    import ring_pkg::*;
#(
    parameter int DATA_WIDTH = 64,
    parameter int IDX_WIDTH  = 6,
    parameter int ADDR_WIDTH = 32,
    parameter int IDLE_BITS  = 4
)
(
    input  logic                     clk,
    input  logic                     resetb,

    // Producer
    input  logic [DATA_WIDTH-1:0]    tx_data,
    input  logic                     tx_enable,
    output logic                     tx_rdy,

    // Memory write port
    output logic                     mem_req,
    output req_type_t                mem_type,
    output logic [ADDR_WIDTH-1:0]    mem_addr,
    output logic [DATA_WIDTH-1:0]    mem_data,
    input  logic                     mem_gnt,
    input  logic                     mem_ready,

    // Wishbone classic slave
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [WB_DATA_WIDTH-1:0] wb_dat_w,
    output logic [WB_DATA_WIDTH-1:0] wb_dat_r,
    output logic                     wb_ack
);

    logic [DATA_WIDTH-1:0] head_data;
    logic                  head_valid;
    logic                  head_deq;

    logic                  ring_en;
    logic [ADDR_WIDTH-1:0] ring_base;
    logic [IDX_WIDTH-1:0]  oldest_idx;
    logic [IDX_WIDTH-1:0]  published_idx;

    // Input buffer absorbs producer lines while the writer waits for grants
    line_fifo #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_line_fifo (
        .clk       (clk),
        .resetb    (resetb),
        .enq_data  (tx_data),
        .enq_en    (tx_enable),
        .not_full  (tx_rdy),
        .first     (head_data),
        .deq_en    (head_deq),
        .not_empty (head_valid)
    );

    ring_csr #(
        .IDX_WIDTH  (IDX_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_ring_csr (
        .clk           (clk),
        .resetb        (resetb),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .ring_en       (ring_en),
        .ring_base     (ring_base),
        .oldest_idx    (oldest_idx),
        .published_idx (published_idx)
    );

    ring_writer #(
        .DATA_WIDTH (DATA_WIDTH),
        .IDX_WIDTH  (IDX_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .IDLE_BITS  (IDLE_BITS)
    ) i_ring_writer (
        .clk           (clk),
        .resetb        (resetb),
        .head_data     (head_data),
        .head_valid    (head_valid),
        .head_deq      (head_deq),
        .ring_en       (ring_en),
        .ring_base     (ring_base),
        .oldest_idx    (oldest_idx),
        .published_idx (published_idx),
        .mem_req       (mem_req),
        .mem_type      (mem_type),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .mem_gnt       (mem_gnt),
        .mem_ready     (mem_ready)
    );

endmodule

`default_nettype wire

// File: testbench/ring_checker.sv
// ============================================================
// Ring reference model that checks granted memory requests and
// published index reads
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module ring_checker
    import ring_pkg::*;
#(
    parameter int DATA_WIDTH = 64,
    parameter int IDX_WIDTH  = 6,
    parameter int ADDR_WIDTH = 32
)
(
    input  wire logic                     clk,
    input  wire logic                     resetb,
    input  wire logic [DATA_WIDTH-1:0]    tx_data,
    input  wire logic                     tx_enable,
    input  wire logic                     tx_rdy,
    input  wire logic                     mem_req,
    input  wire req_type_t                mem_type,
    input  wire logic [ADDR_WIDTH-1:0]    mem_addr,
    input  wire logic [DATA_WIDTH-1:0]    mem_data,
    input  wire logic                     mem_gnt,
    input  wire logic                     wb_cyc,
    input  wire logic                     wb_stb,
    input  wire logic                     wb_we,
    input  wire logic [WB_ADDR_WIDTH-1:0] wb_adr,
    input  wire logic [WB_DATA_WIDTH-1:0] wb_dat_w,
    input  wire logic [WB_DATA_WIDTH-1:0] wb_dat_r,
    input  wire logic                     wb_ack
);

    localparam int RING_SIZE = 1 << IDX_WIDTH;
    // Lines allowed between publishes: a quarter ring plus a little slack
    localparam int MAX_UNFENCED = RING_SIZE / 4 + 4;

    logic [DATA_WIDTH-1:0] expected[$];
    logic [DATA_WIDTH-1:0] exp_data;
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [ADDR_WIDTH-1:0] base;
    int  cur_idx;
    int  published;
    int  oldest;
    int  since_publish;
    int  lines_granted;
    int  errors;
    bit  enabled;

    always @(posedge clk)
    begin
        if (!resetb)
        begin
            expected.delete();
            base          = '0;
            cur_idx       = 0;
            published     = 0;
            oldest        = 0;
            since_publish = 0;
            lines_granted = 0;
            errors        = 0;
            enabled       = 1'b0;
        end
        else
        begin
            // Register traffic first, so writes are known before the grants they allow
            if (wb_cyc && wb_stb && wb_ack && wb_we)
            begin
                if (wb_adr == REG_CTRL)
                    enabled = wb_dat_w[0];
                if (wb_adr == REG_BASE)
                    base = wb_dat_w[ADDR_WIDTH-1:0];
                if (wb_adr == REG_OLDEST)
                    oldest = wb_dat_w % RING_SIZE;
            end
            if (wb_cyc && wb_stb && wb_ack && !wb_we && (wb_adr == REG_PUBLISHED) &&
                (wb_dat_r != published))
            begin
                $display("ERR %0t: published index read %0d, model %0d",
                         $time, wb_dat_r, published);
                errors = errors + 1;
            end

            if (mem_req && !enabled)
            begin
                $display("ERR %0t: memory request while the writer is disabled", $time);
                errors = errors + 1;
            end

            if (mem_req && mem_gnt && (mem_type == REQ_LINE))
            begin
                exp_addr = base + ADDR_WIDTH'(cur_idx);
                if (expected.size() == 0)
                begin
                    $display("ERR %0t: line written with no producer line pending", $time);
                    errors = errors + 1;
                end
                else
                begin
                    exp_data = expected.pop_front();
                    if ((mem_data != exp_data) || (mem_addr != exp_addr))
                    begin
                        $display("ERR %0t: line at %h data %h, expected at %h data %h",
                                 $time, mem_addr, mem_data, exp_addr, exp_data);
                        errors = errors + 1;
                    end
                end
                if (((cur_idx + 1) % RING_SIZE) == oldest)
                begin
                    $display("ERR %0t: line written into a full ring", $time);
                    errors = errors + 1;
                end
                cur_idx       = (cur_idx + 1) % RING_SIZE;
                since_publish = since_publish + 1;
                lines_granted = lines_granted + 1;
                if (since_publish > MAX_UNFENCED)
                begin
                    $display("ERR %0t: %0d lines written without a fence",
                             $time, since_publish);
                    errors = errors + 1;
                end
            end
            else if (mem_req && mem_gnt)
            begin
                // Fence commits everything written so far
                if (mem_addr != '0)
                begin
                    $display("ERR %0t: fence with address %h", $time, mem_addr);
                    errors = errors + 1;
                end
                published     = cur_idx;
                since_publish = 0;
            end

            // Lines taken by the buffer on this edge join the queue last
            if (tx_enable && tx_rdy)
                expected.push_back(tx_data);
        end
    end

endmodule

`default_nettype wire

// File: testbench/ring_assertions.sv
// ============================================================
// Concurrent checks on the memory port handshake, ring room and
// the Wishbone acknowledge
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module ring_assertions
    import ring_pkg::*;
#(
    parameter int DATA_WIDTH = 64,
    parameter int IDX_WIDTH  = 6,
    parameter int ADDR_WIDTH = 32
)
(
    input wire logic                  clk,
    input wire logic                  resetb,
    input wire logic                  mem_req,
    input wire req_type_t             mem_type,
    input wire logic [ADDR_WIDTH-1:0] mem_addr,
    input wire logic [DATA_WIDTH-1:0] mem_data,
    input wire logic                  mem_gnt,
    input wire logic [ADDR_WIDTH-1:0] ring_base,
    input wire logic [IDX_WIDTH-1:0]  oldest_idx,
    input wire logic                  wb_cyc,
    input wire logic                  wb_stb,
    input wire logic                  wb_ack
);

    logic [IDX_WIDTH-1:0] line_idx;
    assign line_idx = IDX_WIDTH'(mem_addr - ring_base);

    // A stalled request holds all of its fields
    held_until_grant: assert property (@(posedge clk) disable iff (!resetb)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_type) &&
                                $stable(mem_addr) && $stable(mem_data))
        else $error("memory request changed before its grant");

    no_line_when_full: assert property (@(posedge clk) disable iff (!resetb)
        mem_req && (mem_type == REQ_LINE) |-> (line_idx + IDX_WIDTH'(1)) != oldest_idx)
        else $error("line request with the ring full");

    // A fresh strobe is answered on the next edge, for exactly one cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetb)
        wb_cyc && $rose(wb_stb) |=> wb_ack ##1 !wb_ack)
        else $error("Wishbone acknowledge missing or longer than one cycle");

endmodule

bind host_ring_top ring_assertions #(
    .DATA_WIDTH (DATA_WIDTH),
    .IDX_WIDTH  (IDX_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
) i_ring_assertions (
    .clk        (clk),
    .resetb     (resetb),
    .mem_req    (mem_req),
    .mem_type   (mem_type),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .mem_gnt    (mem_gnt),
    .ring_base  (ring_base),
    .oldest_idx (oldest_idx),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack)
);

`default_nettype wire

// File: testbench/tb_top.sv
// ============================================================
// Testbench top for the host ring channel: clock, reset, random
// producer, memory responder and Wishbone host model
// ============================================================
`timescale 1ns/1ns
`default_nettype none

module tb_top
    import ring_pkg::*;
;
    localparam int DATA_WIDTH = 64;
    localparam int IDX_WIDTH  = 6;
    localparam int ADDR_WIDTH = 32;
    localparam int RING_SIZE  = 1 << IDX_WIDTH;
    localparam int NUM_LINES  = 600;
    // About four times the expected length of the run
    localparam int MAX_CYCLES = 20000;
    localparam logic [31:0] BASE_ADDR = 32'h0000_4a00;

    logic                     clk;
    logic                     resetb;
    logic [DATA_WIDTH-1:0]    tx_data;
    logic                     tx_enable;
    logic                     tx_rdy;
    logic                     mem_req;
    req_type_t                mem_type;
    logic [ADDR_WIDTH-1:0]    mem_addr;
    logic [DATA_WIDTH-1:0]    mem_data;
    logic                     mem_gnt;
    logic                     mem_ready;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [WB_ADDR_WIDTH-1:0] wb_adr;
    logic [WB_DATA_WIDTH-1:0] wb_dat_w;
    logic [WB_DATA_WIDTH-1:0] wb_dat_r;
    logic                     wb_ack;

    integer seed = 32'h4287;
    int     lines_sent;
    int     tb_errors;
    int     cycles;
    logic   accepted;
    logic [31:0] rd_val;

    host_ring_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .IDX_WIDTH  (IDX_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .IDLE_BITS  (4)
    ) i_host_ring_top (
        .clk       (clk),
        .resetb    (resetb),
        .tx_data   (tx_data),
        .tx_enable (tx_enable),
        .tx_rdy    (tx_rdy),
        .mem_req   (mem_req),
        .mem_type  (mem_type),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_gnt   (mem_gnt),
        .mem_ready (mem_ready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    ring_checker #(
        .DATA_WIDTH (DATA_WIDTH),
        .IDX_WIDTH  (IDX_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_ring_checker (
        .clk       (clk),
        .resetb    (resetb),
        .tx_data   (tx_data),
        .tx_enable (tx_enable),
        .tx_rdy    (tx_rdy),
        .mem_req   (mem_req),
        .mem_type  (mem_type),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_gnt   (mem_gnt),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    // 100 ns clock
    always #50 clk = !clk;

    // ============================================================
    // Producer and memory responder
    // ============================================================

    // All random draws live in this one block so the sequence is repeatable
    always @(posedge clk)
    begin
        if (resetb)
        begin
            accepted = tx_enable && tx_rdy;
            if (accepted)
                lines_sent = lines_sent + 1;

            // A line stays offered until the buffer takes it
            if (!tx_enable || accepted)
            begin
                if ((lines_sent < NUM_LINES) && (($random(seed) & 3) != 0))
                begin
                    tx_enable <= 1'b1;
                    tx_data   <= {$random(seed), $random(seed)};
                end
                else
                begin
                    tx_enable <= 1'b0;
                end
            end

            // Roughly seven grants in ten
            mem_gnt   <= ((($random(seed) & 32'h7fff_ffff) % 10) < 7);
            mem_ready <= (($random(seed) & 1) != 0);
        end
    end

    // ============================================================
    // Wishbone host model
    // ============================================================

    // One classic cycle, held until the slave acknowledges
    task automatic wb_access(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        begin
            @(posedge clk);
            wb_cyc   <= 1'b1;
            wb_stb   <= 1'b1;
            wb_we    <= we;
            wb_adr   <= adr;
            wb_dat_w <= wdata;
            @(posedge clk);
            while (!wb_ack)
                @(posedge clk);
            rdata = wb_dat_r;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    endtask

    task automatic wait_cycles(input int n);
        begin
            repeat (n) @(posedge clk);
        end
    endtask

    // Prints the closing counts and the verdict
    task automatic end_run();
        begin
            $display("Errors: checker %0d, testbench %0d; lines granted %0d of %0d",
                     i_ring_checker.errors, tb_errors,
                     i_ring_checker.lines_granted, NUM_LINES);
            if ((i_ring_checker.errors == 0) && (tb_errors == 0))
                $display("TEST PASS");
            else
                $display("TEST FAIL");
            $finish;
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        resetb     = 1'b0;
        tx_data    = '0;
        tx_enable  = 1'b0;
        mem_gnt    = 1'b0;
        mem_ready  = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        lines_sent = 0;
        tb_errors  = 0;
        repeat (16) @(posedge clk);
        resetb <= 1'b1;

        // Writer still disabled, so the buffer must fill and hold the producer off
        wb_access(1'b1, REG_BASE, BASE_ADDR, rd_val);
        wait_cycles(20);
        if (tx_rdy)
        begin
            $display("ERR %0t: tx_rdy still high with the writer disabled", $time);
            tb_errors = tb_errors + 1;
        end
        wb_access(1'b1, REG_CTRL, 32'h1, rd_val);

        // Host holds the oldest index at zero until the ring is full
        while (i_ring_checker.lines_granted < RING_SIZE - 1)
            @(posedge clk);
        wait_cycles(40);
        if (i_ring_checker.lines_granted != RING_SIZE - 1)
        begin
            $display("ERR %0t: %0d lines written into a ring of %0d entries",
                     $time, i_ring_checker.lines_granted, RING_SIZE);
            tb_errors = tb_errors + 1;
        end

        // Consume whatever has been published until every line is out
        rd_val = 32'hffff_ffff;
        while ((i_ring_checker.lines_granted < NUM_LINES) ||
               (rd_val != (NUM_LINES % RING_SIZE)))
        begin
            wait_cycles(8);
            wb_access(1'b0, REG_PUBLISHED, 32'h0, rd_val);
            wb_access(1'b1, REG_OLDEST, rd_val, rd_val);
            wb_access(1'b0, REG_PUBLISHED, 32'h0, rd_val);
        end
        wait_cycles(4);
        end_run();
    end

    // Run limit
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial cycles = 0;

endmodule

`default_nettype wire

// File: tb.f
logic/ring_pkg.sv
logic/line_fifo.sv
logic/ring_csr.sv
logic/ring_writer.sv
logic/host_ring_top.sv
testbench/ring_checker.sv
testbench/ring_assertions.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the host ring testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f tb.f -o tb_sim

output="$(./obj_dir/tb_sim)"
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi
